// ==== Bender.yml ====
package:
  name: pipe_core

export_include_dirs:
  - common

sources:
  # Design sources in compile order
  - include_dirs:
      - common
    files:
      - common/cpuPkg.sv
      - src/instrDecode.sv
      - src/regFile.sv
      - src/aluFlags.sv
      - src/branchUnit.sv
      - hazard/hazardDetect.sv
      - src/pipeCore.sv
  # Testbench sources
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tbClock.sv
      - testbench/pipeCore_chk.sv
      - testbench/tbTop.sv

// ==== build.f ====
+incdir+common
common/cpuPkg.sv
src/instrDecode.sv
src/regFile.sv
src/aluFlags.sv
src/branchUnit.sv
hazard/hazardDetect.sv
src/pipeCore.sv
testbench/tbClock.sv
testbench/pipeCore_chk.sv
testbench/tbTop.sv

// ==== common/cpuPkg.sv ====
// Opcode and condition encodings, instruction word views and the flag register
// Modules pull these in with a wildcard import in their header
package cpuPkg;

  // Top nibble of every instruction word
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    XOR = 4'h2,
    LLB = 4'h3,                 // Load sign-extended 8-bit immediate
    LW  = 4'h4,
    SW  = 4'h5,
    B   = 4'h6,                 // PC-relative, conditional
    BR  = 4'h7,                 // Target in Rs, conditional
    HLT = 4'hF
  } opcodeT;

  // Branch conditions, tested against the flag register
  typedef enum logic [2:0] {
    NE  = 3'd0,
    EQ  = 3'd1,
    GT  = 3'd2,
    LT  = 3'd3,
    GE  = 3'd4,
    LE  = 3'd5,
    OV  = 3'd6,
    UNC = 3'd7
  } condT;

  // ALU, memory and LLB layout
  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [3:0] rs;             // High half of imm8 for LLB
    logic [3:0] rt;             // imm4 for LW/SW, low half of imm8 for LLB
  } regFormT;

  // B and BR layout, BR keeps Rs in bits 7:4
  typedef struct packed {
    opcodeT     opcode;
    condT       cond;
    logic [8:0] imm9;           // Word offset from PC+2
  } branchFormT;

  // Same 16 bits read two ways
  typedef union packed {
    regFormT    regForm;
    branchFormT branchForm;
  } instrU;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

endpackage

// ==== common/cpu_params.svh ====
// Machine-wide widths and constants for the 16-bit pipeline
// Include in every file that sizes a data word or a register id
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath sizing
`define WORD_W   16             // Data and instruction width
`define REG_ID_W 4              // Sixteen architectural registers

// Start address of the first fetch
`define RESET_PC 16'h0000

// Bubble word loaded by a flush
// ADD r0, r0, r0 so no register is written and no flag moves
`define NOP_WORD 16'h0000

`endif

// ==== hazard/hazardDetect.sv ====
// Pipeline hazard control for load-to-use, B and BR
// Produces the PC hold, IF/ID hold and the two flush levels for pipeCore
`include "cpu_params.svh"

module hazardDetect (
  input  logic [`REG_ID_W-1:0] srcReg1,
  input  logic [`REG_ID_W-1:0] srcReg2,
  input  logic                 idExRegWrite,
  input  logic [`REG_ID_W-1:0] idExRd,
  input  logic [`REG_ID_W-1:0] exMemRd,
  input  logic                 exMemRegWrite,
  input  logic                 idExMemRead,
  input  logic                 idMemWrite,
  input  logic                 idExZEn,
  input  logic                 idExNvEn,
  input  logic                 branch,
  input  logic                 branchReg,
  input  logic                 updatePc,
  input  logic                 hlt,
  output logic                 pcStall,
  output logic                 ifIdStall,
  output logic                 idFlush,
  output logic                 ifFlush
);

  logic loadUse;
  logic brFlagWait;
  logic brRegWait;
  logic stall;

  // Load in EX feeding an ID read, SW data in Rt can use MEM-MEM forwarding
  assign loadUse = idExMemRead && (idExRd != '0) &&
                   ((idExRd == srcReg1) || ((idExRd == srcReg2) && !idMemWrite));

  // Branch must see flags written by the instruction in EX
  assign brFlagWait = branch && (idExZEn || idExNvEn);

  // BR needs Rs from EX or MEM since branches resolve in ID
  assign brRegWait = branchReg && (srcReg1 != '0) &&
                     ((idExRegWrite && (idExRd == srcReg1)) ||
                      (exMemRegWrite && (exMemRd == srcReg1)));

  assign stall     = loadUse || brFlagWait || brRegWait;
  assign pcStall   = stall || hlt;
  assign ifIdStall = stall;
  assign idFlush   = stall;
  assign ifFlush   = updatePc;

endmodule

// ==== src/aluFlags.sv ====
// EX-stage ALU with the Z/N/V flag register
// Result is combinational, flags are written on the edge that ends EX
`include "cpu_params.svh"

module aluFlags import cpuPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  opcodeT             aluOp,
  input  logic [`WORD_W-1:0] opA,
  input  logic [`WORD_W-1:0] opB,
  input  logic               zEn,          // ADD, SUB, XOR
  input  logic               nvEn,         // ADD, SUB
  output logic [`WORD_W-1:0] result,
  output flagsT              flags
);

  logic [`WORD_W-1:0] sum;
  logic [`WORD_W-1:0] diff;
  logic               ovAdd;
  logic               ovSub;
  logic               ovNow;

  assign sum  = opA + opB;                 // Also the LW/SW address
  assign diff = opA - opB;

  // Two's complement overflow from operand and result signs
  assign ovAdd = (opA[`WORD_W-1] == opB[`WORD_W-1]) && (sum[`WORD_W-1] != opA[`WORD_W-1]);
  assign ovSub = (opA[`WORD_W-1] != opB[`WORD_W-1]) && (diff[`WORD_W-1] != opA[`WORD_W-1]);
  assign ovNow = (aluOp == SUB) ? ovSub : ovAdd;

  always_comb begin
    case (aluOp)
      SUB:     result = diff;
      XOR:     result = opA ^ opB;
      LLB:     result = opB;               // Immediate passes straight through
      default: result = sum;               // ADD, LW, SW
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flag register, each group written only by its enable
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (zEn) begin
        flags.z <= (result == '0);
      end
      if (nvEn) begin
        flags.n <= result[`WORD_W-1];
        flags.v <= ovNow;
      end
    end
  end

endmodule

// ==== src/branchUnit.sv ====
// ID-stage branch resolution
// Tests the condition against the flag register and forms the redirect target
`include "cpu_params.svh"

module branchUnit import cpuPkg::*; (
  input  logic [`WORD_W-1:0] pcPlus2,      // Address after the branch
  input  logic [`WORD_W-1:0] imm,          // Sign-extended imm9
  input  logic [`WORD_W-1:0] rsData,
  input  condT               cond,
  input  flagsT              flags,
  input  logic               branch,
  input  logic               branchReg,
  output logic               updatePc,
  output logic [`WORD_W-1:0] target
);

  logic condMet;

  always_comb begin
    case (cond)
      NE:      condMet = ~flags.z;
      EQ:      condMet = flags.z;
      GT:      condMet = ~flags.z & ~flags.n;
      LT:      condMet = flags.n;
      GE:      condMet = flags.z | ~flags.n;
      LE:      condMet = flags.z | flags.n;
      OV:      condMet = flags.v;
      default: condMet = 1'b1;             // UNC
    endcase
  end

  assign updatePc = branch & condMet;

  // Word offset for B, register target for BR
  assign target = branchReg ? rsData : pcPlus2 + {imm[`WORD_W-2:0], 1'b0};

endmodule

// ==== src/instrDecode.sv ====
// ID-stage decoder that splits the fetched word into register ids, immediate and control
// Purely combinational, sits between the IF/ID register and the ID/EX register
`include "cpu_params.svh"

module instrDecode import cpuPkg::*; (
  input  instrU                instr,
  output logic [`REG_ID_W-1:0] srcReg1,    // Rs read port
  output logic [`REG_ID_W-1:0] srcReg2,    // Rt read port, or store data for SW
  output logic [`REG_ID_W-1:0] rd,
  output logic [`WORD_W-1:0]   imm,
  output logic                 regWrite,
  output logic                 memRead,
  output logic                 memWrite,
  output logic                 zEn,
  output logic                 nvEn,
  output logic                 branch,     // B or BR
  output logic                 branchReg,  // BR only
  output logic                 hlt,
  output logic                 useImm,     // ALU B operand comes from imm
  output opcodeT               aluOp,
  output condT                 cond
);

  opcodeT op;
  logic   rdNonZero;                       // r0 destinations write nothing and set no flags

  assign op        = instr.regForm.opcode;
  assign rdNonZero = (instr.regForm.rd != '0);
  assign aluOp     = op;
  assign cond      = instr.branchForm.cond;
  assign rd        = instr.regForm.rd;

  always_comb begin
    srcReg1   = instr.regForm.rs;
    srcReg2   = instr.regForm.rt;
    imm       = '0;
    regWrite  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    zEn       = 1'b0;
    nvEn      = 1'b0;
    branch    = 1'b0;
    branchReg = 1'b0;
    hlt       = 1'b0;
    useImm    = 1'b0;
    case (op)
      ADD, SUB: begin
        regWrite = rdNonZero;
        zEn      = rdNonZero;
        nvEn     = rdNonZero;
      end
      XOR: begin
        regWrite = rdNonZero;
        zEn      = rdNonZero;              // Z only
      end
      LLB: begin
        srcReg1  = '0;                     // Rs/Rt bits are immediate here
        srcReg2  = '0;
        regWrite = rdNonZero;
        useImm   = 1'b1;
        imm      = {{8{instr.regForm.rs[3]}}, instr.regForm.rs, instr.regForm.rt};
      end
      LW, SW: begin
        useImm = 1'b1;                     // Address is Rs + imm4
        imm    = {{12{instr.regForm.rt[3]}}, instr.regForm.rt};
        if (op == SW) begin
          srcReg2  = instr.regForm.rd;     // Store data lives in the rd field
          memWrite = 1'b1;
        end else begin
          srcReg2  = '0;
          memRead  = 1'b1;
          regWrite = rdNonZero;
        end
      end
      B: begin
        srcReg1 = '0;
        srcReg2 = '0;
        branch  = 1'b1;
        imm     = {{7{instr.branchForm.imm9[8]}}, instr.branchForm.imm9};
      end
      BR: begin
        srcReg2   = '0;                    // Only Rs is read
        branch    = 1'b1;
        branchReg = 1'b1;
      end
      HLT: begin
        srcReg1 = '0;
        srcReg2 = '0;
        hlt     = 1'b1;
      end
      default: begin                       // Unused opcodes behave as a bubble
        srcReg1 = '0;
        srcReg2 = '0;
      end
    endcase
  end

endmodule

// ==== src/pipeCore.sv ====
// Five-stage in-order core with PC, stage registers, forwarding and halt latch
// Instruction and data memories hang off the loose imem and dmem ports
`include "cpu_params.svh"

module pipeCore import cpuPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  output logic [`WORD_W-1:0] imemAddr,
  input  logic [`WORD_W-1:0] imemData,     // Combinational fetch
  output logic [`WORD_W-1:0] dmemAddr,
  output logic [`WORD_W-1:0] dmemWdata,
  output logic               dmemWe,       // One pulse per SW in MEM
  input  logic [`WORD_W-1:0] dmemRdata,
  output logic               halted
);

  // IF
  logic [`WORD_W-1:0]   pc;
  logic [`WORD_W-1:0]   pcPlus2;
  logic                 fetchStop;         // HLT has been decoded
  // IF/ID
  instrU                ifIdInstr;
  logic [`WORD_W-1:0]   ifIdPcPlus2;
  // ID
  logic [`REG_ID_W-1:0] srcReg1;
  logic [`REG_ID_W-1:0] srcReg2;
  logic [`REG_ID_W-1:0] idRd;
  logic [`WORD_W-1:0]   idImm;
  logic                 idRegWrite;
  logic                 idMemRead;
  logic                 idMemWrite;
  logic                 idZEn;
  logic                 idNvEn;
  logic                 idBranch;
  logic                 idBranchReg;
  logic                 idHlt;
  logic                 idUseImm;
  opcodeT               idAluOp;
  condT                 idCond;
  logic [`WORD_W-1:0]   rsData;
  logic [`WORD_W-1:0]   rtData;
  logic                 brUpdate;
  logic                 takeBranch;        // Redirect that is not held by a stall
  logic [`WORD_W-1:0]   brTarget;
  logic                 pcStall;
  logic                 ifIdStall;
  logic                 idFlush;
  logic                 ifFlush;
  flagsT                flags;
  // ID/EX
  logic                 idExRegWrite;
  logic                 idExMemRead;
  logic                 idExMemWrite;
  logic                 idExZEn;
  logic                 idExNvEn;
  logic                 idExHlt;
  logic                 idExUseImm;
  opcodeT               idExAluOp;
  logic [`REG_ID_W-1:0] idExRd;
  logic [`REG_ID_W-1:0] idExRs;
  logic [`REG_ID_W-1:0] idExRt;
  logic [`WORD_W-1:0]   idExRsData;
  logic [`WORD_W-1:0]   idExRtData;
  logic [`WORD_W-1:0]   idExImm;
  // EX
  logic [`WORD_W-1:0]   fwdA;
  logic [`WORD_W-1:0]   fwdB;
  logic [`WORD_W-1:0]   opB;
  logic [`WORD_W-1:0]   exResult;
  // EX/MEM
  logic                 exMemRegWrite;
  logic                 exMemMemRead;
  logic                 exMemMemWrite;
  logic                 exMemHlt;
  logic [`REG_ID_W-1:0] exMemRd;
  logic [`REG_ID_W-1:0] exMemRt;           // SW data register for MEM-MEM
  logic [`WORD_W-1:0]   exMemAlu;
  logic [`WORD_W-1:0]   exMemStore;
  logic                 memFwdOk;
  // MEM/WB
  logic                 memWbRegWrite;
  logic                 memWbMemRead;
  logic                 memWbHlt;
  logic [`REG_ID_W-1:0] memWbRd;
  logic [`WORD_W-1:0]   memWbAlu;
  logic [`WORD_W-1:0]   memWbLoad;
  logic [`WORD_W-1:0]   wbData;

  ////////////////////////////////////////////////////////////////////////////
  // IF
  ////////////////////////////////////////////////////////////////////////////
  assign imemAddr = pc;
  assign pcPlus2  = pc + `WORD_W'(2);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc        <= `RESET_PC;
      fetchStop <= 1'b0;
    end else begin
      if (takeBranch) pc <= brTarget;
      else if (!pcStall && !fetchStop) pc <= pcPlus2;
      if (idHlt) fetchStop <= 1'b1;       // Freeze fetch for good
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifIdInstr <= `NOP_WORD;
    end else if (!ifIdStall) begin
      // Wrong-path slot and anything after HLT become bubbles
      if (ifFlush || idHlt || fetchStop) ifIdInstr <= `NOP_WORD;
      else ifIdInstr <= imemData;
    end
  end

  always_ff @(posedge clk) begin
    if (!ifIdStall) ifIdPcPlus2 <= pcPlus2;
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID
  ////////////////////////////////////////////////////////////////////////////
  instrDecode decode0 (
    .instr(ifIdInstr), .srcReg1(srcReg1), .srcReg2(srcReg2), .rd(idRd),
    .imm(idImm), .regWrite(idRegWrite), .memRead(idMemRead),
    .memWrite(idMemWrite), .zEn(idZEn), .nvEn(idNvEn), .branch(idBranch),
    .branchReg(idBranchReg), .hlt(idHlt), .useImm(idUseImm),
    .aluOp(idAluOp), .cond(idCond)
  );

  regFile regs0 (
    .clk(clk), .rstN(rstN), .rdAddr1(srcReg1), .rdAddr2(srcReg2),
    .wrAddr(memWbRd), .wrData(wbData), .wrEn(memWbRegWrite),
    .rdData1(rsData), .rdData2(rtData)
  );

  branchUnit branch0 (
    .pcPlus2(ifIdPcPlus2), .imm(idImm), .rsData(rsData), .cond(idCond),
    .flags(flags), .branch(idBranch), .branchReg(idBranchReg),
    .updatePc(brUpdate), .target(brTarget)
  );

  assign takeBranch = brUpdate & ~ifIdStall;   // Stalled branch waits

  hazardDetect hazard0 (
    .srcReg1(srcReg1), .srcReg2(srcReg2), .idExRegWrite(idExRegWrite),
    .idExRd(idExRd), .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite),
    .idExMemRead(idExMemRead), .idMemWrite(idMemWrite), .idExZEn(idExZEn),
    .idExNvEn(idExNvEn), .branch(idBranch), .branchReg(idBranchReg),
    .updatePc(takeBranch), .hlt(idHlt), .pcStall(pcStall),
    .ifIdStall(ifIdStall), .idFlush(idFlush), .ifFlush(ifFlush)
  );

  // ID/EX, a flushed slot becomes ADD r0, r0, r0
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExZEn      <= 1'b0;
      idExNvEn     <= 1'b0;
      idExHlt      <= 1'b0;
      idExUseImm   <= 1'b0;
      idExAluOp    <= ADD;
      idExRd       <= '0;
      idExRs       <= '0;
      idExRt       <= '0;
      idExRsData   <= '0;
      idExRtData   <= '0;
      idExImm      <= '0;
    end else begin
      idExRegWrite <= idRegWrite & ~idFlush;
      idExMemRead  <= idMemRead & ~idFlush;
      idExMemWrite <= idMemWrite & ~idFlush;
      idExZEn      <= idZEn & ~idFlush;
      idExNvEn     <= idNvEn & ~idFlush;
      idExHlt      <= idHlt & ~idFlush;
      idExUseImm   <= idUseImm & ~idFlush;
      idExAluOp    <= idFlush ? ADD : idAluOp;
      idExRd       <= idFlush ? '0 : idRd;
      idExRs       <= idFlush ? '0 : srcReg1;
      idExRt       <= idFlush ? '0 : srcReg2;
      idExRsData   <= rsData;
      idExRtData   <= rtData;
      idExImm      <= idImm;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX
  ////////////////////////////////////////////////////////////////////////////
  assign memFwdOk = exMemRegWrite & ~exMemMemRead;   // Load data not ready in MEM

  // MEM result first, then WB, then the register file copy
  always_comb begin
    if (memFwdOk && exMemRd == idExRs) fwdA = exMemAlu;
    else if (memWbRegWrite && memWbRd == idExRs) fwdA = wbData;
    else fwdA = idExRsData;
    if (memFwdOk && exMemRd == idExRt) fwdB = exMemAlu;
    else if (memWbRegWrite && memWbRd == idExRt) fwdB = wbData;
    else fwdB = idExRtData;
  end

  assign opB = idExUseImm ? idExImm : fwdB;    // fwdB stays the SW data

  aluFlags alu0 (
    .clk(clk), .rstN(rstN), .aluOp(idExAluOp), .opA(fwdA), .opB(opB),
    .zEn(idExZEn), .nvEn(idExNvEn), .result(exResult), .flags(flags)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMemRegWrite <= 1'b0;
      exMemMemRead  <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemHlt      <= 1'b0;
      exMemRd       <= '0;
      exMemRt       <= '0;
      exMemAlu      <= '0;
      exMemStore    <= '0;
    end else begin
      exMemRegWrite <= idExRegWrite;
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemHlt      <= idExHlt;
      exMemRd       <= idExRd;
      exMemRt       <= idExRt;
      exMemAlu      <= exResult;
      exMemStore    <= fwdB;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MEM
  ////////////////////////////////////////////////////////////////////////////
  assign dmemAddr  = exMemAlu;
  assign dmemWe    = exMemMemWrite;
  // Load just ahead of a SW hands its word straight to the store
  assign dmemWdata = (memWbRegWrite && memWbRd == exMemRt) ? wbData : exMemStore;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWbRegWrite <= 1'b0;
      memWbMemRead  <= 1'b0;
      memWbHlt      <= 1'b0;
      memWbRd       <= '0;
      memWbAlu      <= '0;
      memWbLoad     <= '0;
    end else begin
      memWbRegWrite <= exMemRegWrite;
      memWbMemRead  <= exMemMemRead;
      memWbHlt      <= exMemHlt;
      memWbRd       <= exMemRd;
      memWbAlu      <= exMemAlu;
      memWbLoad     <= dmemRdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // WB and halt
  ////////////////////////////////////////////////////////////////////////////
  assign wbData = memWbMemRead ? memWbLoad : memWbAlu;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (memWbHlt) begin
      halted <= 1'b1;                      // Sticky until reset
    end
  end

endmodule

// ==== src/regFile.sv ====
// Sixteen-entry register file with two read ports and one write port
// A WB write in the same cycle is forwarded to the ID reads
`include "cpu_params.svh"

module regFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [`REG_ID_W-1:0] rdAddr1,
  input  logic [`REG_ID_W-1:0] rdAddr2,
  input  logic [`REG_ID_W-1:0] wrAddr,
  input  logic [`WORD_W-1:0]   wrData,
  input  logic                 wrEn,
  output logic [`WORD_W-1:0]   rdData1,
  output logic [`WORD_W-1:0]   rdData2
);

  logic [`WORD_W-1:0] regs [0:(1 << `REG_ID_W)-1];
  logic               wrLive;              // Write that actually lands

  assign wrLive = wrEn && (wrAddr != '0);  // r0 stays zero

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < (1 << `REG_ID_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so WB and ID may share a cycle
  assign rdData1 = (wrLive && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
  assign rdData2 = (wrLive && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

// ==== testbench/pipeCore_chk.sv ====
// Port-level assertions for pipeCore, attached by bind below
// Redirect targets match the two taken branches of the test program
`include "cpu_params.svh"

module pipeCoreChk #(
  parameter logic [`WORD_W-1:0] bTarget  = 16'h0034,  // B EQ at 0x30 lands here
  parameter logic [`WORD_W-1:0] brTarget = 16'h003C,  // BR through r11
  parameter logic [`WORD_W-1:0] skipAddr = 16'hDEAD   // Stores placed in skipped slots
) (
  input logic               clk,
  input logic               rstN,
  input logic [`WORD_W-1:0] imemAddr,
  input logic [`WORD_W-1:0] dmemAddr,
  input logic               dmemWe,
  input logic               halted
);

  int failCount = 0;                       // Read by tbTop for the closing line

  // Core is quiet and parked at the reset PC while rstN is low
  resetState: assert property (@(posedge clk)
    !rstN |-> (!dmemWe && !halted && imemAddr == `RESET_PC))
    else begin
      $error("Core outputs not in reset state while rstN is low");
      failCount++;
    end

  // Fetch address steps by 2, holds, or jumps to a known target
  pcMove: assert property (@(posedge clk) disable iff (!rstN)
    $past(rstN) |-> (imemAddr == $past(imemAddr) + 16'd2) ||
                    (imemAddr == $past(imemAddr)) ||
                    (imemAddr == bTarget) || (imemAddr == brTarget))
    else begin
      $error("imemAddr moved to %h from %h", imemAddr, $past(imemAddr));
      failCount++;
    end

  // Wrong-path stores must have been flushed
  noSkippedStore: assert property (@(posedge clk) disable iff (!rstN)
    dmemWe |-> dmemAddr != skipAddr)
    else begin
      $error("Store from a skipped slot reached memory");
      failCount++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Halt is sticky and freezes the ports
  ////////////////////////////////////////////////////////////////////////////
  haltHold: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> (halted && $stable(imemAddr)))
    else begin
      $error("Core left halt or fetched after halting");
      failCount++;
    end

  haltNoStore: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> !dmemWe)
    else begin
      $error("Store issued while halted");
      failCount++;
    end

endmodule

bind pipeCore pipeCoreChk chk0 (.*);

// ==== testbench/tbClock.sv ====
// Clock and reset source for the testbench
// clk has a period of 8, rstN is held low for the first 10 rising edges
module tbClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    #1 rstN = 1'b1;                        // Released just after an edge
  end

endmodule

// ==== testbench/tbTop.sv ====
// Testbench top for pipeCore with memory models, program loader and store checking
// Expected stores come from an in-order model that runs the same program first
`include "cpu_params.svh"

module tbTop import cpuPkg::*; ();

  localparam int IMEM_WORDS     = 128;
  localparam int DMEM_WORDS     = 256;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [`WORD_W-1:0] HALT_WORD = {HLT, 12'h000};

  logic               clk;
  logic               rstN;
  logic [`WORD_W-1:0] imemAddr;
  logic [`WORD_W-1:0] imemData;
  logic [`WORD_W-1:0] dmemAddr;
  logic [`WORD_W-1:0] dmemWdata;
  logic               dmemWe;
  logic [`WORD_W-1:0] dmemRdata;
  logic               halted;

  logic [`WORD_W-1:0] imem [0:IMEM_WORDS-1];
  logic [`WORD_W-1:0] dmem [0:DMEM_WORDS-1];   // Word per even address
  logic [`WORD_W-1:0] expAddr [$];
  logic [`WORD_W-1:0] expData [$];
  int                 progLen    = 0;
  int                 storeErrs  = 0;
  int                 storeCount = 0;
  logic               timedOut   = 1'b0;

  tbClock clock0 (.clk(clk), .rstN(rstN));

  pipeCore dut0 (
    .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe),
    .dmemRdata(dmemRdata), .halted(halted)
  );

  // Combinational memory ports, fetch past the program returns HLT
  assign imemData  = (imemAddr < 2 * IMEM_WORDS) ? imem[imemAddr[7:1]] : HALT_WORD;
  assign dmemRdata = dmem[dmemAddr[8:1]];

  ////////////////////////////////////////////////////////////////////////////
  // Assembler helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [`WORD_W-1:0] encReg(opcodeT op, logic [3:0] rd,
                                                logic [3:0] rs, logic [3:0] rt);
    instrU w;
    w.regForm.opcode = op;
    w.regForm.rd     = rd;
    w.regForm.rs     = rs;
    w.regForm.rt     = rt;
    return w;
  endfunction

  function automatic logic [`WORD_W-1:0] encLlb(logic [3:0] rd, logic [7:0] imm8);
    return encReg(LLB, rd, imm8[7:4], imm8[3:0]);
  endfunction

  function automatic logic [`WORD_W-1:0] encBranch(opcodeT op, condT cond, logic [8:0] imm9);
    instrU w;
    w.branchForm.opcode = op;
    w.branchForm.cond   = cond;
    w.branchForm.imm9   = imm9;                // BR carries Rs in bits 7:4
    return w;
  endfunction

  task automatic emit(input logic [`WORD_W-1:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic loadProgram();
    logic [7:0] k1;
    logic [7:0] k2;
    k1 = 8'($urandom);
    k2 = 8'($urandom);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = HALT_WORD;
    end
    emit(encLlb(4'd1, k1));
    emit(encLlb(4'd2, k2));
    emit(encLlb(4'd3, 8'h10));                 // Data base 0x0010
    emit(encReg(LW, 4'd4, 4'd3, 4'h0));
    emit(encReg(ADD, 4'd5, 4'd4, 4'd2));       // Load-to-use
    emit(encReg(SW, 4'd5, 4'd3, 4'h2));
    emit(encReg(LW, 4'd6, 4'd3, 4'h4));
    emit(encReg(SW, 4'd6, 4'd3, 4'h6));        // MEM-MEM store data
    emit(encReg(ADD, 4'd7, 4'd1, 4'd2));
    emit(encReg(SUB, 4'd8, 4'd7, 4'd1));       // EX forward
    emit(encReg(XOR, 4'd9, 4'd8, 4'd7));       // EX and WB forward
    emit(encReg(SW, 4'd9, 4'd3, 4'h8));        // Offset -8
    // r14 = 0xFFDF doubled eight times = 0xDF00, plus 0xFFAD gives 0xDEAD
    emit(encLlb(4'd14, 8'hDF));
    for (int i = 0; i < 8; i++) begin
      emit(encReg(ADD, 4'd14, 4'd14, 4'd14));
    end
    emit(encLlb(4'd13, 8'hAD));
    emit(encReg(ADD, 4'd14, 4'd14, 4'd13));
    emit(encReg(SUB, 4'd10, 4'd1, 4'd1));      // Z set
    emit(encBranch(B, EQ, 9'd1));              // Taken, at 0x30
    emit(encReg(SW, 4'd1, 4'd14, 4'h0));       // Skipped slot
    emit(encReg(SW, 4'd2, 4'd3, 4'hA));
    emit(encLlb(4'd11, 8'h3C));
    emit(encBranch(BR, UNC, {1'b0, 4'd11, 4'h0}));  // Right after its Rs write
    emit(encReg(SW, 4'd1, 4'd14, 4'h0));       // Skipped slot
    emit(encReg(SW, 4'd7, 4'd3, 4'hC));        // BR lands here at 0x3C
    emit(encBranch(B, NE, 9'd1));              // Not taken
    emit(encReg(SW, 4'd8, 4'd3, 4'hE));
    emit(HALT_WORD);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // In-order model of the instruction set
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic condHolds(condT c, logic z, logic n, logic v);
    case (c)
      NE:      return !z;
      EQ:      return z;
      GT:      return !z && !n;
      LT:      return n;
      GE:      return z || !n;
      LE:      return z || n;
      OV:      return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic runModel();
    logic [`WORD_W-1:0] r [0:15];
    logic [`WORD_W-1:0] mem [0:DMEM_WORDS-1];
    logic [`WORD_W-1:0] pcM;
    logic [`WORD_W-1:0] a;
    logic [`WORD_W-1:0] b;
    logic [`WORD_W-1:0] res;
    logic [`WORD_W-1:0] addr;
    logic               z;
    logic               n;
    logic               v;
    instrU              w;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = dmem[i];
    end
    z   = 1'b0;
    n   = 1'b0;
    v   = 1'b0;
    pcM = `RESET_PC;
    for (int step = 0; step < 4 * IMEM_WORDS; step++) begin
      w    = imem[pcM[7:1]];
      a    = r[w.regForm.rs];
      b    = r[w.regForm.rt];
      addr = a + {{12{w.regForm.rt[3]}}, w.regForm.rt};
      pcM  = pcM + 16'd2;
      if (w.regForm.opcode == HLT) break;
      case (w.regForm.opcode)
        ADD, SUB, XOR: begin
          res = (w.regForm.opcode == ADD) ? a + b : (w.regForm.opcode == SUB) ? a - b : a ^ b;
          if (w.regForm.rd != 4'd0) begin    // r0 target is a bubble
            r[w.regForm.rd] = res;
            z = (res == '0);
            if (w.regForm.opcode == ADD) begin
              n = res[15];
              v = (a[15] == b[15]) && (res[15] != a[15]);
            end else if (w.regForm.opcode == SUB) begin
              n = res[15];
              v = (a[15] != b[15]) && (res[15] != a[15]);
            end
          end
        end
        LLB: if (w.regForm.rd != 4'd0) begin
          r[w.regForm.rd] = {{8{w.regForm.rs[3]}}, w.regForm.rs, w.regForm.rt};
        end
        LW: if (w.regForm.rd != 4'd0) begin
          r[w.regForm.rd] = mem[addr[8:1]];
        end
        SW: begin
          mem[addr[8:1]] = r[w.regForm.rd];
          expAddr.push_back(addr);
          expData.push_back(r[w.regForm.rd]);
        end
        B: if (condHolds(w.branchForm.cond, z, n, v)) begin
          pcM = pcM + {{6{w.branchForm.imm9[8]}}, w.branchForm.imm9, 1'b0};
        end
        BR: if (condHolds(w.branchForm.cond, z, n, v)) begin
          pcM = a;                             // Rs sits in the rs field
        end
        default: ;
      endcase
    end
  endtask

  // Stores are compared and written mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (rstN && dmemWe) begin
      if (storeCount >= expAddr.size()) begin
        storeErrs++;
        $display("Store number %0d at address %h was not expected", storeCount, dmemAddr);
      end else begin
        if (dmemAddr !== expAddr[storeCount]) begin
          storeErrs++;
          $display("[FAIL] dmemAddr got %h expected %h", dmemAddr, expAddr[storeCount]);
        end
        if (dmemWdata !== expData[storeCount]) begin
          storeErrs++;
          $display("[FAIL] dmemWdata got %h expected %h", dmemWdata, expData[storeCount]);
        end
      end
      dmem[dmemAddr[8:1]] = dmemWdata;
      storeCount++;
    end
  end

  initial begin
    int waitCycles;
    void'($urandom(32'h19274818));
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 16'($urandom);
    end
    loadProgram();
    runModel();
    waitCycles = 0;
    while (!rstN && waitCycles < 100) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!rstN) begin
      $display("Reset was never released");
      timedOut = 1'b1;
    end
    waitCycles = 0;
    while (!timedOut && !halted && waitCycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!timedOut && !halted) begin
      $display("Timeout, halted did not rise within %0d cycles", TIMEOUT_CYCLES);
      timedOut = 1'b1;
    end
    repeat (8) @(posedge clk);                 // Halt assertions see a frozen core
    if (storeCount != expAddr.size()) begin
      storeErrs++;
      $display("Saw %0d stores but the model made %0d", storeCount, expAddr.size());
    end
    $display("Errors: stores %0d, assertions %0d, timeouts %0d",
             storeErrs, dut0.chk0.failCount, timedOut);
    if (!timedOut && storeErrs == 0 && dut0.chk0.failCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
